// ==== stimulus_cnt_reg_block.txt ====
// test op addr data mode events expected, all hex
// op 1 write, 2 read, 3 event burst, 4 idle, 0 end; mode {test, cfg}
01 02 00 00 01 00 02
01 02 10 00 01 00 A5
01 02 08 00 01 00 00
01 02 0C 00 01 00 00
01 02 04 00 01 00 00
02 01 00 83 01 00 00
02 02 00 00 01 00 83
02 03 00 00 01 05 0F
02 01 00 87 01 00 00
02 03 00 00 01 24 0B
02 02 0C 00 01 00 0B
03 01 04 02 01 00 00
03 04 00 00 01 01 0B
03 02 08 00 01 00 0B
03 03 00 00 01 02 19
03 02 08 00 01 00 0B
03 01 04 01 01 00 00
03 04 00 00 01 03 00
03 02 0C 00 01 00 00
03 02 04 00 01 00 00
04 01 10 3C 01 00 00
04 02 10 00 01 00 A5
04 01 10 3C 02 00 00
04 02 10 00 02 00 3C
04 03 00 00 01 01 07
04 01 00 00 00 00 00
04 01 04 01 00 00 00
04 04 00 00 00 01 07
04 02 00 00 00 00 00
04 02 10 00 00 00 00
04 02 00 00 01 00 87
05 01 20 FF 03 00 00
05 02 20 00 03 00 00
05 01 05 FF 03 00 00
05 02 00 00 03 00 87
05 02 10 00 03 00 3C
05 04 00 00 03 02 07
00 00 00 00 00 00 00

// ==== all.f ====
reg_bus_pkg.sv
cnt_regmap_pkg.sv
wo_reg.sv
rw_reg.sv
ro_reg.sv
reg_rdata_mux.sv
evt_counter.sv
cnt_reg_block.sv
cnt_reg_block_chk.sv
tb_cnt_reg_block.sv

// ==== Bender.yml ====
package:
  name: cnt_reg_block

sources:
  - reg_bus_pkg.sv
  - cnt_regmap_pkg.sv
  - wo_reg.sv
  - rw_reg.sv
  - ro_reg.sv
  - reg_rdata_mux.sv
  - evt_counter.sv
  - cnt_reg_block.sv
  - target: test
    files:
      - cnt_reg_block_chk.sv
      - tb_cnt_reg_block.sv

// ==== tb_cnt_reg_block.sv ====
//======================================================================
// testbench for the event counter register block
// clock, reset, file-driven stimulus, checks, timeout, summary
//======================================================================

`timescale 1ns/1ns

module tb_cnt_reg_block;

    // columns per stimulus row and row capacity
    localparam int COLS     = 7;
    localparam int MAX_ROWS = 64;

    // operation codes of the stimulus file
    localparam logic [7:0] OP_END    = 8'h00;
    localparam logic [7:0] OP_WRITE  = 8'h01;
    localparam logic [7:0] OP_READ   = 8'h02;
    localparam logic [7:0] OP_EVENTS = 8'h03;
    localparam logic [7:0] OP_IDLE   = 8'h04;

    logic                       i_clk;
    logic                       i_rst_n;
    reg_bus_pkg::reg_req_t      i_req;
    reg_bus_pkg::reg_mode_t     i_mode;
    logic                       i_event;
    logic [reg_bus_pkg::DW-1:0] o_rdata;
    logic                       o_rvalid;
    logic [reg_bus_pkg::DW-1:0] o_count;

    logic [7:0] stim [0:COLS*MAX_ROWS-1];
    int         err_cnt;
    int         chk_cnt;
    int         cycle_cnt;
    int         cycle_limit;

    cnt_reg_block i_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .i_mode   (i_mode),
        .i_event  (i_event),
        .o_rdata  (o_rdata),
        .o_rvalid (o_rvalid),
        .o_count  (o_count)
    );

    bind cnt_reg_block cnt_reg_block_chk u_chk (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ren    (i_req.ren),
        .i_rvalid (o_rvalid),
        .i_pulse  (cmd_pulse)
    );

    // 8 ns period
    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    //==================================================================
    // timeout
    //==================================================================

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // behavior number from the first column
    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'h01:   return "reset_defaults";
            8'h02:   return "ctrl_access";
            8'h03:   return "clear_and_snapshot";
            8'h04:   return "mode_gating";
            8'h05:   return "unmapped_address";
            default: return "unknown_test";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, exp, act);
        end
    endtask

    //==================================================================
    // one stimulus row, entered and left on a falling edge
    //==================================================================

    task automatic run_row(input int row);
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] n;
        logic [7:0] exp;
        string      name;
        op     = stim[row*COLS+1];
        addr   = stim[row*COLS+2];
        data   = stim[row*COLS+3];
        n      = stim[row*COLS+5];
        exp    = stim[row*COLS+6];
        name   = $sformatf("%s row %0d", test_name(stim[row*COLS]), row);
        i_mode = stim[row*COLS+4][1:0];
        case (op)
            OP_WRITE: begin
                i_req.addr  = addr;
                i_req.wdata = data;
                i_req.wen   = 1'b1;
                @(negedge i_clk);
                i_req.wen   = 1'b0;
            end
            OP_READ: begin
                i_req.addr = addr;
                i_req.ren  = 1'b1;
                @(negedge i_clk);
                i_req.ren  = 1'b0;
                if (o_rvalid !== 1'b1) begin
                    err_cnt++;
                    $display("%s: read of address 0x%02h returned no o_rvalid", name, addr);
                end
                check_value(name, exp, o_rdata);
            end
            OP_EVENTS: begin
                i_event = 1'b1;
                repeat (n) @(negedge i_clk);
                i_event = 1'b0;
                check_value(name, exp, o_count);
            end
            OP_IDLE: begin
                repeat (n) @(negedge i_clk);
                check_value(name, exp, o_count);
            end
            default: begin
                err_cnt++;
                $display("%s: operation code 0x%02h is not known", name, op);
            end
        endcase
    endtask

    //==================================================================
    // main sequence
    //==================================================================

    initial begin
        int         rows;
        int         total;
        int         asrt_errs;
        logic [7:0] op;
        err_cnt     = 0;
        chk_cnt     = 0;
        cycle_cnt   = 0;
        cycle_limit = 1000;
        i_req       = '0;
        i_mode      = '0;
        i_event     = 1'b0;
        i_rst_n     = 1'b0;
        $readmemh("stimulus_cnt_reg_block.txt", stim);
        // rows up to the end marker, unread entries stay unknown
        rows = 0;
        while (rows < MAX_ROWS && !$isunknown(stim[rows*COLS+1]) &&
               stim[rows*COLS+1] !== OP_END) begin
            rows++;
        end
        // reset plus cycles asked for by each row
        total = 6;
        for (int r = 0; r < rows; r++) begin
            op = stim[r*COLS+1];
            if (op == OP_EVENTS || op == OP_IDLE) begin
                total += stim[r*COLS+5];
            end else begin
                total += 1;
            end
        end
        cycle_limit = 4 * total + 100;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        if (rows == 0) begin
            err_cnt++;
            $display("stimulus file could not be read or holds no operations");
        end else begin
            for (int r = 0; r < rows; r++) begin
                run_row(r);
            end
        end
        asrt_errs = i_dut.u_chk.err_cnt;
        $display("rows %0d, checks %0d, check errors %0d, assertion errors %0d",
                 rows, chk_cnt, err_cnt, asrt_errs);
        if (err_cnt == 0 && asrt_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== cnt_reg_block_chk.sv ====
//======================================================================
// bound assertions for the counter register block
// read valid timing, cmd pulse width, valid low in reset
//======================================================================

`timescale 1ns/1ns

module cnt_reg_block_chk (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic                       i_ren,
    input logic                       i_rvalid,
    input logic [reg_bus_pkg::DW-1:0] i_pulse
);

    // failed assertions, read by the testbench at the end
    int err_cnt = 0;

    // valid exactly one cycle after a read strobe
    a_rvalid_after_ren: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_ren |=> i_rvalid
    ) else begin
        err_cnt++;
        $error("o_rvalid missing one cycle after a read strobe");
    end

    a_no_rvalid_without_ren: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !i_ren |=> !i_rvalid
    ) else begin
        err_cnt++;
        $error("o_rvalid high without a read strobe one cycle before");
    end

    // cmd pulse word lasts a single cycle
    a_pulse_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) (|i_pulse) |=> !(|i_pulse)
    ) else begin
        err_cnt++;
        $error("cmd pulse word high for two consecutive cycles");
    end

    a_rvalid_low_in_reset: assert property (
        @(posedge i_clk) !i_rst_n |-> !i_rvalid
    ) else begin
        err_cnt++;
        $error("o_rvalid high during reset");
    end

endmodule

// ==== cnt_reg_block.sv ====
//======================================================================
// event counter register block, top level
// register cells, read mux and counter wired together
//======================================================================

`timescale 1ns/1ns

module cnt_reg_block (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  reg_bus_pkg::reg_req_t      i_req,
    input  reg_bus_pkg::reg_mode_t     i_mode,
    input  logic                       i_event,
    output logic [reg_bus_pkg::DW-1:0] o_rdata,
    output logic                       o_rvalid,
    output logic [reg_bus_pkg::DW-1:0] o_count
);

    // per-cell read words
    logic [reg_bus_pkg::DW-1:0] rd_ctrl;
    logic [reg_bus_pkg::DW-1:0] rd_cmd;
    logic [reg_bus_pkg::DW-1:0] rd_snap;
    logic [reg_bus_pkg::DW-1:0] rd_count;
    logic [reg_bus_pkg::DW-1:0] rd_scratch;

    // register to counter
    cnt_regmap_pkg::ctrl_word_u ctrl_word;
    logic [reg_bus_pkg::DW-1:0] cmd_pulse;
    logic [reg_bus_pkg::DW-1:0] snap_val;

    //==================================================================
    // register cells
    //==================================================================

    // enable and step, both modes
    rw_reg #(
        .REG_ADDR    (cnt_regmap_pkg::ADDR_CTRL),
        .DEFAULT_VAL (cnt_regmap_pkg::CTRL_DEFAULT)
    ) u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_mode     (i_mode),
        .o_rdata    (rd_ctrl),
        .o_reg_data (ctrl_word.raw)
    );

    // clear and snapshot pulses
    wo_reg #(
        .REG_ADDR (cnt_regmap_pkg::ADDR_CMD)
    ) u_cmd (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .i_mode  (i_mode),
        .o_rdata (rd_cmd),
        .o_pulse (cmd_pulse)
    );

    ro_reg #(
        .REG_ADDR (cnt_regmap_pkg::ADDR_SNAP)
    ) u_snap (
        .i_req     (i_req),
        .i_mode    (i_mode),
        .i_hw_data (snap_val),
        .o_rdata   (rd_snap)
    );

    ro_reg #(
        .REG_ADDR (cnt_regmap_pkg::ADDR_COUNT)
    ) u_count (
        .i_req     (i_req),
        .i_mode    (i_mode),
        .i_hw_data (o_count),
        .o_rdata   (rd_count)
    );

    // writable in test mode only, value drives nothing
    rw_reg #(
        .REG_ADDR            (cnt_regmap_pkg::ADDR_SCRATCH),
        .DEFAULT_VAL         (cnt_regmap_pkg::SCRATCH_DEFAULT),
        .SUPPORT_CFG_MODE_WR (1'b0)
    ) u_scratch (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_mode     (i_mode),
        .o_rdata    (rd_scratch),
        .o_reg_data ()
    );

    //==================================================================
    // read path and counter
    //==================================================================

    reg_rdata_mux u_rdata_mux (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ren       (i_req.ren),
        .i_rdata_vec ({rd_ctrl, rd_cmd, rd_snap, rd_count, rd_scratch}),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid)
    );

    evt_counter u_counter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (ctrl_word),
        .i_cmd   (cmd_pulse),
        .i_event (i_event),
        .o_count (o_count),
        .o_snap  (snap_val)
    );

endmodule

// ==== evt_counter.sv ====
//======================================================================
// event counter
// enabled events add the step, cmd pulses clear and snapshot
//======================================================================

`timescale 1ns/1ns

module evt_counter (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  cnt_regmap_pkg::ctrl_word_u i_ctrl,
    input  logic [reg_bus_pkg::DW-1:0] i_cmd,
    input  logic                       i_event,
    output logic [reg_bus_pkg::DW-1:0] o_count,
    output logic [reg_bus_pkg::DW-1:0] o_snap
);

    logic                       clr;
    logic                       snap;
    logic                       inc;
    logic [reg_bus_pkg::DW-1:0] step;

    // cmd pulse decode
    assign clr  = i_cmd[cnt_regmap_pkg::CMD_CLR_BIT];
    assign snap = i_cmd[cnt_regmap_pkg::CMD_SNAP_BIT];

    // ctrl fields, step zero-extended to count width
    assign inc  = i_ctrl.fields.enable & i_event;
    assign step = {{(reg_bus_pkg::DW-3){1'b0}}, i_ctrl.fields.step};

    //==================================================================
    // count and snapshot
    //==================================================================

    // clear wins over increment, count wraps mod 256
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (clr) begin
            o_count <= '0;
        end else if (inc) begin
            o_count <= o_count + step;
        end
    end

    // captures the count as it stands before this edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_snap <= '0;
        end else if (snap) begin
            o_snap <= o_count;
        end
    end

endmodule

// ==== reg_rdata_mux.sv ====
//======================================================================
// read data combiner
// ors the cell read words, registers data and valid flag
//======================================================================

`timescale 1ns/1ns

module reg_rdata_mux (
    input  logic                                                   i_clk,
    input  logic                                                   i_rst_n,
    input  logic                                                   i_ren,
    input  logic [cnt_regmap_pkg::NUM_RD_WORDS*reg_bus_pkg::DW-1:0] i_rdata_vec,
    output logic [reg_bus_pkg::DW-1:0]                             o_rdata,
    output logic                                                   o_rvalid
);

    logic [reg_bus_pkg::DW-1:0] rdata_or;

    // at most one cell drives a non-zero word
    always_comb begin
        rdata_or = '0;
        for (int i = 0; i < cnt_regmap_pkg::NUM_RD_WORDS; i++) begin
            rdata_or |= i_rdata_vec[i*reg_bus_pkg::DW +: reg_bus_pkg::DW];
        end
    end

    // fixed one-cycle read latency
    // valid follows every strobe, hit or not
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata  <= '0;
            o_rvalid <= 1'b0;
        end else begin
            o_rdata  <= rdata_or;
            o_rvalid <= i_ren;
        end
    end

endmodule

// ==== ro_reg.sv ====
//======================================================================
// read-only register cell
// returns a hardware value on a permitted read hit
//======================================================================

`timescale 1ns/1ns

module ro_reg #(
    parameter logic [reg_bus_pkg::AW-1:0] REG_ADDR             = '0,
    parameter bit                         SUPPORT_TEST_MODE_RD = 1'b1,
    parameter bit                         SUPPORT_CFG_MODE_RD  = 1'b1
) (
    input  reg_bus_pkg::reg_req_t      i_req,
    input  reg_bus_pkg::reg_mode_t     i_mode,
    input  logic [reg_bus_pkg::DW-1:0] i_hw_data,
    output logic [reg_bus_pkg::DW-1:0] o_rdata
);

    logic hit;
    logic ren;

    // writes to this address fall through untouched
    assign hit = (i_req.addr == REG_ADDR);

    // read allowed if any active mode permits it
    assign ren = i_req.ren & hit &
                 ((i_mode.test_mode & SUPPORT_TEST_MODE_RD) |
                  (i_mode.cfg_mode  & SUPPORT_CFG_MODE_RD));

    // purely combinational, the mux registers the result
    assign o_rdata = ren ? i_hw_data : '0;

endmodule

// ==== rw_reg.sv ====
//======================================================================
// read/write register cell
// mode-gated write and readback, value from reset default
//======================================================================

`timescale 1ns/1ns

module rw_reg #(
    parameter logic [reg_bus_pkg::AW-1:0] REG_ADDR             = '0,
    parameter logic [reg_bus_pkg::DW-1:0] DEFAULT_VAL          = '0,
    parameter bit                         SUPPORT_TEST_MODE_WR = 1'b1,
    parameter bit                         SUPPORT_TEST_MODE_RD = 1'b1,
    parameter bit                         SUPPORT_CFG_MODE_WR  = 1'b1,
    parameter bit                         SUPPORT_CFG_MODE_RD  = 1'b1
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  reg_bus_pkg::reg_req_t      i_req,
    input  reg_bus_pkg::reg_mode_t     i_mode,
    output logic [reg_bus_pkg::DW-1:0] o_rdata,
    output logic [reg_bus_pkg::DW-1:0] o_reg_data
);

    logic hit;
    logic wen;
    logic ren;

    assign hit = (i_req.addr == REG_ADDR);
    // write and read permissions checked separately per mode
    assign wen = i_req.wen & hit &
                 ((i_mode.test_mode & SUPPORT_TEST_MODE_WR) |
                  (i_mode.cfg_mode  & SUPPORT_CFG_MODE_WR));
    assign ren = i_req.ren & hit &
                 ((i_mode.test_mode & SUPPORT_TEST_MODE_RD) |
                  (i_mode.cfg_mode  & SUPPORT_CFG_MODE_RD));

    // holds until a permitted write hit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_data <= DEFAULT_VAL;
        end else if (wen) begin
            o_reg_data <= i_req.wdata;
        end
    end

    // zero unless this cell is being read
    assign o_rdata = ren ? o_reg_data : '0;

endmodule

// ==== wo_reg.sv ====
//======================================================================
// write-only register cell
// a permitted write becomes a one-cycle pulse word, reads return zero
//======================================================================

`timescale 1ns/1ns

module wo_reg #(
    parameter logic [reg_bus_pkg::AW-1:0] REG_ADDR             = '0,
    parameter bit                         SUPPORT_TEST_MODE_WR = 1'b1,
    parameter bit                         SUPPORT_CFG_MODE_WR  = 1'b1
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  reg_bus_pkg::reg_req_t      i_req,
    input  reg_bus_pkg::reg_mode_t     i_mode,
    output logic [reg_bus_pkg::DW-1:0] o_rdata,
    output logic [reg_bus_pkg::DW-1:0] o_pulse
);

    logic hit;
    logic wen;

    // address match
    assign hit = (i_req.addr == REG_ADDR);
    // write allowed if any active mode permits it
    assign wen = i_req.wen & hit &
                 ((i_mode.test_mode & SUPPORT_TEST_MODE_WR) |
                  (i_mode.cfg_mode  & SUPPORT_CFG_MODE_WR));

    // pulse word, self-clearing after one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pulse <= '0;
        end else begin
            o_pulse <= wen ? i_req.wdata : '0;
        end
    end

    // cannot be read back
    assign o_rdata = '0;

endmodule

// ==== cnt_regmap_pkg.sv ====
//======================================================================
// event counter register map package
// register addresses, reset defaults, cmd bit positions, ctrl word
//======================================================================

package cnt_regmap_pkg;

    //==================================================================
    // register addresses
    //==================================================================

    localparam logic [reg_bus_pkg::AW-1:0] ADDR_CTRL    = 8'h00;
    localparam logic [reg_bus_pkg::AW-1:0] ADDR_CMD     = 8'h04;
    localparam logic [reg_bus_pkg::AW-1:0] ADDR_SNAP    = 8'h08;
    localparam logic [reg_bus_pkg::AW-1:0] ADDR_COUNT   = 8'h0C;
    localparam logic [reg_bus_pkg::AW-1:0] ADDR_SCRATCH = 8'h10;

    // number of cells feeding the read mux
    localparam int NUM_RD_WORDS = 5;

    //==================================================================
    // reset defaults
    //==================================================================

    // counter disabled after reset
    localparam logic [reg_bus_pkg::DW-1:0] CTRL_DEFAULT    = 8'h02;
    localparam logic [reg_bus_pkg::DW-1:0] SCRATCH_DEFAULT = 8'hA5;

    //==================================================================
    // cmd pulse bits
    //==================================================================

    // clear the count
    localparam int CMD_CLR_BIT  = 0;
    // copy count into snap
    localparam int CMD_SNAP_BIT = 1;

    //==================================================================
    // ctrl word
    //==================================================================

    // field view used by the counter
    typedef struct packed {
        logic       enable;
        logic [3:0] rsvd;
        logic [2:0] step;
    } ctrl_fields_t;

    // bus side sees raw, counter sees fields
    typedef union packed {
        logic [reg_bus_pkg::DW-1:0] raw;
        ctrl_fields_t               fields;
    } ctrl_word_u;

endpackage

// ==== reg_bus_pkg.sv ====
//======================================================================
// register bus package
// data and address widths, bus request struct, access mode struct
//======================================================================

package reg_bus_pkg;

    //==================================================================
    // widths
    //==================================================================

    // data width of every register
    localparam int DW = 8;
    // address width of the register bus
    localparam int AW = 8;

    //==================================================================
    // bus request
    //==================================================================

    // single-cycle strobes, no handshake
    // 18 bits: wen + ren + addr + wdata
    typedef struct packed {
        logic          wen;
        logic          ren;
        logic [AW-1:0] addr;
        logic [DW-1:0] wdata;
    } reg_req_t;

    //==================================================================
    // access mode
    //==================================================================

    // mode levels that gate every access
    // both low means no access is allowed at all
    typedef struct packed {
        logic test_mode;
        logic cfg_mode;
    } reg_mode_t;

endpackage
